//--- rv_core_macros.svh
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// core geometry, RV32 only

// data path and address width
`define XLEN 32

// register index, 5 bits for x0..x31
`define REG_ADDR_W 5

// architectural register count
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h8000_0000

`endif

//--- rv_core_pkg.sv
package rv_core_pkg;

  // major opcodes, values are the inst[6:0] encodings
  // op_illegal takes an encoding no kept instruction uses
  typedef enum logic [6:0] {
    // addi only, funct3 is not looked at
    op_imm     = 7'b001_0011,
    op_lui     = 7'b011_0111,
    op_auipc   = 7'b001_0111,
    op_jal     = 7'b110_1111,
    op_jalr    = 7'b110_0111,
    // word load
    op_load    = 7'b000_0011,
    // word store
    op_store   = 7'b010_0011,
    // ebreak
    op_system  = 7'b111_0011,
    // anything else, no write, pc+4
    op_illegal = 7'b000_0000
  } opcode_e;

endpackage

//--- decode_if.sv
`timescale 1ns/1ns
`include "rv_core_macros.svh"

interface decode_if import rv_core_pkg::*; ();

  // decoded major opcode
  opcode_e                opcode;

  // register indices straight from the instruction word
  logic [`REG_ADDR_W-1:0] rd;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;

  // sign extended, U type already shifted up
  logic [`XLEN-1:0]       imm;

  // register write, already low for x0 and after halt
  logic                   reg_we;

  // driven by the input side
  modport frontend (output opcode, rd, rs1, rs2, imm, reg_we);

  // read by execute and the memory stage
  modport consumer (input opcode, rd, rs1, rs2, imm, reg_we);

endinterface

//--- rv_frontend.sv
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module rv_frontend import rv_core_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [`XLEN-1:0] inst,
  input  logic             jump,
  input  logic [`XLEN-1:0] jump_target,
  output logic [`XLEN-1:0] pc,
  output logic             halted,
  decode_if.frontend       dec
);

  // full ebreak encoding, ecall and csr ops are not kept
  localparam logic [`XLEN-1:0] EBREAK_INST = 32'h0010_0073;

  logic [`XLEN-1:0] pc_plus4;
  logic [`XLEN-1:0] pc_next;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm;
  opcode_e          opcode;
  logic             reg_we;
  logic             halt_req;

  // immediate formats, sign bit is always inst[31]
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // opcode field to enum
  always_comb begin
    case (inst[6:0])
      op_imm:    opcode = op_imm;
      op_lui:    opcode = op_lui;
      op_auipc:  opcode = op_auipc;
      op_jal:    opcode = op_jal;
      op_jalr:   opcode = op_jalr;
      op_load:   opcode = op_load;
      op_store:  opcode = op_store;
      op_system: opcode = (inst == EBREAK_INST) ? op_system : op_illegal;
      default:   opcode = op_illegal;
    endcase
    // stopped core decodes nothing
    if (halted) begin
      opcode = op_illegal;
    end
  end

  // one immediate per opcode
  always_comb begin
    case (opcode)
      op_imm, op_jalr, op_load: imm = imm_i;
      op_lui, op_auipc:         imm = imm_u;
      op_jal:                   imm = imm_j;
      op_store:                 imm = imm_s;
      default:                  imm = '0;
    endcase
  end

  // writers of rd, x0 writes dropped here
  always_comb begin
    case (opcode)
      op_imm, op_lui, op_auipc, op_jal, op_jalr, op_load: reg_we = (inst[11:7] != '0);
      default:                                            reg_we = 1'b0;
    endcase
  end

  assign dec.opcode = opcode;
  assign dec.rd     = inst[11:7];
  assign dec.rs1    = inst[19:15];
  assign dec.rs2    = inst[24:20];
  assign dec.imm    = imm;
  assign dec.reg_we = reg_we;

  assign halt_req = (opcode == op_system);

  // sequential next pc, hold once stopped
  assign pc_plus4 = pc + `XLEN'd4;
  assign pc_next  = halted ? pc : (jump ? jump_target : pc_plus4);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= `RESET_PC;
      halted <= 1'b0;
    end else begin
      pc <= pc_next;
      // sticky until reset
      if (halt_req) begin
        halted <= 1'b1;
      end
    end
  end

endmodule

//--- rv_regfile.sv
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module rv_regfile import rv_core_pkg::*; (
  input  logic                   clk,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic                   we,
  input  logic [`XLEN-1:0]       wb_data,
  output logic [`XLEN-1:0]       rs1_data,
  output logic [`XLEN-1:0]       rs2_data
);

  // x1..x31 only, x0 has no storage
  logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

  // write at the end of the cycle
  always_ff @(posedge clk) begin
    if (we && (rd != '0)) begin
      regs[rd] <= wb_data;
    end
  end

  // combinational reads, index zero reads as zero
  always_comb begin
    if (rs1 == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2];
    end
  end

endmodule

//--- rv_execute.sv
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module rv_execute import rv_core_pkg::*; (
  decode_if.consumer       dec,
  input  logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] rs1_data,
  output logic [`XLEN-1:0] sum,
  output logic [`XLEN-1:0] link,
  output logic [`XLEN-1:0] jump_target,
  output logic             jump
);

  logic [`XLEN-1:0] op_a;
  logic             is_jalr;

  // first adder operand
  always_comb begin
    case (dec.opcode)
      // pc relative
      op_auipc, op_jal: op_a = pc;
      // lui is just the shifted immediate
      op_lui:           op_a = '0;
      // addi, jalr, load, store
      default:          op_a = rs1_data;
    endcase
  end

  // single adder serves results, addresses and targets
  assign sum = op_a + dec.imm;

  // return address for jal and jalr
  assign link = pc + `XLEN'd4;

  assign is_jalr = (dec.opcode == op_jalr);

  // redirect on both jumps
  assign jump = (dec.opcode == op_jal) || is_jalr;

  // jalr target has bit zero cleared
  assign jump_target = is_jalr ? {sum[`XLEN-1:1], 1'b0} : sum;

endmodule

//--- rv_mem_stage.sv
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module rv_mem_stage import rv_core_pkg::*; (
  decode_if.consumer       dec,
  input  logic [`XLEN-1:0] sum,
  input  logic [`XLEN-1:0] link,
  input  logic [`XLEN-1:0] rs2_data,
  input  logic [`XLEN-1:0] dmem_rdata,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wdata,
  output logic [`XLEN-1:0] wb_data,
  output logic             dmem_we,
  output logic             dmem_re
);

  // word access only, no byte lanes
  assign dmem_re = (dec.opcode == op_load);
  assign dmem_we = (dec.opcode == op_store);

  // address is always the adder output
  assign dmem_addr = sum;

  // store data from rs2
  assign dmem_wdata = rs2_data;

  // write-back select
  always_comb begin
    case (dec.opcode)
      // memory answers in this cycle
      op_load:         wb_data = dmem_rdata;
      op_jal, op_jalr: wb_data = link;
      // addi, lui, auipc
      default:         wb_data = sum;
    endcase
  end

endmodule

//--- rv_core.sv
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module rv_core import rv_core_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [`XLEN-1:0] inst,
  output logic [`XLEN-1:0] pc,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wdata,
  output logic             dmem_we,
  output logic             dmem_re,
  input  logic [`XLEN-1:0] dmem_rdata,
  output logic             halted
);

  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic [`XLEN-1:0] sum;
  logic [`XLEN-1:0] link;
  logic [`XLEN-1:0] jump_target;
  logic [`XLEN-1:0] wb_data;
  logic             jump;

  // decoded instruction, input side to the rest
  decode_if dec ();

  // pc, halt flag and decode
  rv_frontend frontend_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .inst        (inst),
    .jump        (jump),
    .jump_target (jump_target),
    .pc          (pc),
    .halted      (halted),
    .dec         (dec.frontend)
  );

  rv_regfile regfile_inst (
    .clk      (clk),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rd       (dec.rd),
    .we       (dec.reg_we),
    .wb_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_execute execute_inst (
    .dec         (dec.consumer),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .sum         (sum),
    .link        (link),
    .jump_target (jump_target),
    .jump        (jump)
  );

  // memory request and write-back mux
  rv_mem_stage mem_stage_inst (
    .dec        (dec.consumer),
    .sum        (sum),
    .link       (link),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .wb_data    (wb_data),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re)
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  // free running, starts low so the first rising edge is at half a period
  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- rv_core_properties.sv
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module rv_core_properties (
  input logic             clk,
  input logic             arst_n,
  input logic [`XLEN-1:0] pc,
  input logic             halted,
  input logic             dmem_we,
  input logic             dmem_re
);

  // first edge after reset release still shows the reset vector
  reset_vector: assert property (@(posedge clk) $rose(arst_n) |-> pc == `RESET_PC)
    else $error("pc is not at the reset vector after reset release");

  // word fetches only
  pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  // halt is sticky until reset
  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else $error("halted dropped without a reset");

  // stopped core keeps its pc
  halt_pc_stable: assert property (@(posedge clk) disable iff (!arst_n) halted |=> $stable(pc))
    else $error("pc moved while halted");

  // one memory access kind per cycle
  mem_exclusive: assert property (@(posedge clk) disable iff (!arst_n) !(dmem_we && dmem_re))
    else $error("dmem_we and dmem_re are high together");

endmodule

bind rv_core rv_core_properties properties_inst (
  .clk     (clk),
  .arst_n  (arst_n),
  .pc      (pc),
  .halted  (halted),
  .dmem_we (dmem_we),
  .dmem_re (dmem_re)
);

//--- tb_rv_core.sv
`timescale 1ns/1ns
`include "rv_core_macros.svh"

module tb_rv_core import rv_core_pkg::*; ();

  localparam int               CLK_PERIOD = 20;
  // addi x0, x0, 0
  localparam logic [`XLEN-1:0] NOP_INST   = 32'h0000_0013;

  logic             clk;
  logic             arst_n;
  logic [`XLEN-1:0] inst;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] dmem_addr;
  logic [`XLEN-1:0] dmem_wdata;
  logic             dmem_we;
  logic             dmem_re;
  logic [`XLEN-1:0] dmem_rdata;
  logic             halted;

  // one entry per line of the test file
  string            name_q[$];
  logic [`XLEN-1:0] inst_q[$];
  logic [`XLEN-1:0] rdata_q[$];
  logic [`XLEN-1:0] pc_q[$];
  logic             we_q[$];
  logic             re_q[$];
  logic [`XLEN-1:0] addr_q[$];
  logic [`XLEN-1:0] wdata_q[$];
  logic             halt_q[$];

  // watchdog
  int cycle_count = 0;
  int cycle_limit = 0;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) clock_gen_inst (.clk(clk));

  rv_core rv_core_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst       (inst),
    .pc         (pc),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_re    (dmem_re),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string test, input string what,
                            input logic [`XLEN-1:0] expected, input logic [`XLEN-1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("error: %s %s expected %h actual %h",
                               test, what, expected, actual));
    end
  endtask

  task automatic check_bit(input string test, input string what,
                           input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("error: %s %s expected %b actual %b",
                               test, what, expected, actual));
    end
  endtask

  task automatic check_opcode(input string test, input opcode_e expected, input opcode_e actual);
    if (actual !== expected) begin
      report_failure($sformatf("error: %s opcode expected %s actual %h",
                               test, expected.name(), actual));
    end
  endtask

  // major opcode per the base ISA encodings, nothing decodes once stopped
  function automatic opcode_e expected_opcode(input logic [`XLEN-1:0] word, input logic stopped);
    if (stopped) begin
      return op_illegal;
    end
    case (word[6:0])
      7'b001_0011: return op_imm;
      7'b011_0111: return op_lui;
      7'b001_0111: return op_auipc;
      7'b110_1111: return op_jal;
      7'b110_0111: return op_jalr;
      7'b000_0011: return op_load;
      7'b010_0011: return op_store;
      // only the exact ebreak word is a system op
      7'b111_0011: return (word == 32'h0010_0073) ? op_system : op_illegal;
      default:     return op_illegal;
    endcase
  endfunction

  // whole file goes into the queues before the clock starts
  task automatic load_tests();
    int               fd;
    int               fields;
    string            line;
    string            name;
    logic [`XLEN-1:0] f_inst;
    logic [`XLEN-1:0] f_rdata;
    logic [`XLEN-1:0] f_pc;
    logic [`XLEN-1:0] f_we;
    logic [`XLEN-1:0] f_re;
    logic [`XLEN-1:0] f_addr;
    logic [`XLEN-1:0] f_wdata;
    logic [`XLEN-1:0] f_halt;
    fd = $fopen("rv_core_tests.txt", "r");
    if (fd == 0) begin
      report_failure("could not open rv_core_tests.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // skip comment lines
      if (line.len() > 0 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, f_inst, f_rdata,
                         f_pc, f_we, f_re, f_addr, f_wdata, f_halt);
        if (fields == 9) begin
          name_q.push_back(name);
          inst_q.push_back(f_inst);
          rdata_q.push_back(f_rdata);
          pc_q.push_back(f_pc);
          we_q.push_back(f_we[0]);
          re_q.push_back(f_re[0]);
          addr_q.push_back(f_addr);
          wdata_q.push_back(f_wdata);
          halt_q.push_back(f_halt[0]);
        end else if (fields > 0) begin
          report_failure({"malformed line in rv_core_tests.txt: ", line});
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic check_line(input int idx);
    string test;
    test = name_q[idx];
    check_word(test, "pc", pc_q[idx], pc);
    check_bit(test, "halted", halt_q[idx], halted);
    check_bit(test, "dmem_we", we_q[idx], dmem_we);
    check_bit(test, "dmem_re", re_q[idx], dmem_re);
    // address and data only matter with a request
    if (we_q[idx] || re_q[idx]) begin
      check_word(test, "dmem_addr", addr_q[idx], dmem_addr);
    end
    if (we_q[idx]) begin
      check_word(test, "dmem_wdata", wdata_q[idx], dmem_wdata);
    end
    check_opcode(test, expected_opcode(inst_q[idx], halt_q[idx]), rv_core_inst.dec.opcode);
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      report_failure($sformatf("timeout, run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin
    arst_n     = 1'b0;
    inst       = NOP_INST;
    dmem_rdata = '0;
    load_tests();
    cycle_limit = name_q.size() + 20;
    // five cycles of reset with a nop on the bus
    repeat (5) @(negedge clk);
    check_word("reset", "pc", `RESET_PC, pc);
    check_bit("reset", "halted", 1'b0, halted);
    check_bit("reset", "dmem_we", 1'b0, dmem_we);
    check_bit("reset", "dmem_re", 1'b0, dmem_re);
    arst_n = 1'b1;
    // one line per cycle, outputs settle well before the next rising edge
    foreach (name_q[i]) begin
      inst       = inst_q[i];
      dmem_rdata = rdata_q[i];
      #(CLK_PERIOD / 4);
      check_line(i);
      @(negedge clk);
    end
    if (name_q.size() == 0) begin
      report_failure("no test lines found in rv_core_tests.txt");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- rv_core_tests.txt
# name inst dmem_rdata exp_pc exp_we exp_re exp_addr exp_wdata exp_halted
# hex values, addr and wdata only matter when a request is expected
reset_nop       00000013 00000000 80000000 0 0 00000000 00000000 0
addi_x1         12000093 00000000 80000004 0 0 00000000 00000000 0
sw_x1           00102823 00000000 80000008 1 0 00000010 00000120 0
addi_neg_x2     fff00113 00000000 8000000c 0 0 00000000 00000000 0
sw_x2           00202a23 00000000 80000010 1 0 00000014 ffffffff 0
lui_x3          123451b7 00000000 80000014 0 0 00000000 00000000 0
addi_x3         67818193 00000000 80000018 0 0 00000000 00000000 0
sw_x3_base_x1   fe30ae23 00000000 8000001c 1 0 0000011c 12345678 0
auipc_x4        00001217 00000000 80000020 0 0 00000000 00000000 0
sw_x4           00402023 00000000 80000024 1 0 00000000 80001020 0
addi_x0         00500013 00000000 80000028 0 0 00000000 00000000 0
sw_x0           00002223 00000000 8000002c 1 0 00000004 00000000 0
lui_neg_x5      fffff2b7 00000000 80000030 0 0 00000000 00000000 0
sw_x5           02502023 00000000 80000034 1 0 00000020 fffff000 0
jal_x1          010000ef 00000000 80000038 0 0 00000000 00000000 0
sw_link_jal     00102423 00000000 80000048 1 0 00000008 8000003c 0
lui_x6          80000337 00000000 8000004c 0 0 00000000 00000000 0
jalr_x7_odd     061303e7 00000000 80000050 0 0 00000000 00000000 0
sw_link_jalr    00702623 00000000 80000060 1 0 0000000c 80000054 0
jal_back        ff9ff06f 00000000 80000064 0 0 00000000 00000000 0
lw_x8           01002403 deadbeef 8000005c 0 1 00000010 00000000 0
sw_x8           00802a23 00000000 80000060 1 0 00000014 deadbeef 0
lw_x9_neg       ff81a483 0badf00d 80000064 0 1 12345670 00000000 0
sw_x9           00902c23 00000000 80000068 1 0 00000018 0badf00d 0
illegal_add     002081b3 00000000 8000006c 0 0 00000000 00000000 0
sw_x3_kept      00302e23 00000000 80000070 1 0 0000001c 12345678 0
ebreak          00100073 00000000 80000074 0 0 00000000 00000000 0
halt_sw         00102023 00000000 80000078 0 0 00000000 00000000 1
halt_lw         00002083 12345678 80000078 0 0 00000000 00000000 1
halt_jal        ff9ff06f 00000000 80000078 0 0 00000000 00000000 1

//--- sources.f
+incdir+.
rv_core_pkg.sv
decode_if.sv
rv_frontend.sv
rv_regfile.sv
rv_execute.sv
rv_mem_stage.sv
rv_core.sv
tb_clock_gen.sv
rv_core_properties.sv
tb_rv_core.sv

//--- Makefile
SRCS := $(shell grep -v '^+' sources.f) rv_core_macros.svh

.PHONY: run clean

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core

obj_dir/Vtb_rv_core: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_rv_core -Mdir obj_dir -f sources.f

clean:
	rm -rf obj_dir
